// ==== design/mdio_pkg.sv ====
/*
 * MDIO master shared definitions
 * Management clock timing, frame layout, register map and FSM types
 */
package mdio_pkg;

    // Management clock timing in system clock cycles
    localparam int phase_cycles = 25;
    localparam int phase_count_bits = $clog2(phase_cycles);

    // Frame layout
    localparam int preamble_bits = 32;
    localparam int frame_bits = 64;
    localparam int turnaround_bit = 46;

    typedef logic [5:0] bit_index_t;

    // Opcode field held in command word bits 29 to 28
    typedef enum logic [1:0] {
        opcode_write = 2'b01,
        opcode_read  = 2'b10
    } mdio_opcode_t;

    typedef enum logic [2:0] {
        state_idle,
        state_clock_high,
        state_clock_low,
        state_finish,
        state_done
    } frame_state_t;

    // Register byte offsets
    localparam logic [11:0] reg_int_enable = 12'h008;
    localparam logic [11:0] reg_int_status = 12'h00c;
    localparam logic [11:0] reg_control = 12'h020;
    localparam logic [11:0] reg_mdio_command = 12'h024;
    localparam logic [11:0] reg_mdio_read = 12'h028;

    // Interrupt status bit positions
    localparam int int_mdio_done_bit = 18;
    localparam int int_phy_bit = 19;

    localparam int control_phy_reset_bit = 2;

endpackage

// ==== design/mdio_phase_timer.sv ====
`timescale 1ns/1ps

/*
 * Management clock phase timer
 * Pulses phase_end once per phase while the frame FSM keeps run high
 */
module mdio_phase_timer (
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic phase_end
);
    import mdio_pkg::*;

    localparam logic [phase_count_bits-1:0] reload_value = phase_count_bits'(phase_cycles - 1);

    logic [phase_count_bits-1:0] count;

    // Count sits at the reload value whenever the FSM is not running,
    // so the first phase of a frame is always a full one
    always_ff @(posedge clock) begin
        if (reset || !run) begin
            count <= reload_value;
        end else if (count == '0) begin
            count <= reload_value;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign phase_end = run && (count == '0);

endmodule

// ==== design/mdio_frame_fsm.sv ====
`timescale 1ns/1ps

/*
 * MDIO frame sequencer
 * Walks the 64 frame bits, toggles the management clock on each phase end
 * and tells the datapath when to present and when to capture a bit
 */
module mdio_frame_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 phase_end,
    output logic                 run,
    output logic                 load,
    output logic                 drive_bit,
    output logic                 sample_bit,
    output logic                 done,
    output logic                 mdio_clock,
    output mdio_pkg::bit_index_t bit_index
);
    import mdio_pkg::*;

    frame_state_t state;
    bit_index_t   bit_count;
    logic         frame_last;

    assign run = (state == state_clock_high) || (state == state_clock_low) ||
                 (state == state_finish);
    assign done = (state == state_done);
    assign load = (state == state_idle) && start;

    // Falling edge presents the next bit, rising edge samples it
    assign drive_bit = (state == state_clock_high) && phase_end;
    assign sample_bit = (state == state_clock_low) && phase_end;

    // While low the counter is already one past the bit on the line
    assign bit_index = (state == state_clock_low) ? bit_index_t'(bit_count - 1'b1) : bit_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
            bit_count <= '0;
            frame_last <= 1'b0;
            mdio_clock <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    // Start phase is a high phase with the line still released
                    if (start) begin
                        state <= state_clock_high;
                        bit_count <= '0;
                        frame_last <= 1'b0;
                        mdio_clock <= 1'b1;
                    end
                end
                state_clock_high: begin
                    if (phase_end) begin
                        mdio_clock <= 1'b0;
                        if (frame_last) begin
                            // Counter has wrapped to 0 so the datapath drives an idle one
                            state <= state_finish;
                        end else begin
                            state <= state_clock_low;
                            bit_count <= bit_count + 1'b1;
                            frame_last <= (bit_count == bit_index_t'(frame_bits - 1));
                        end
                    end
                end
                state_clock_low: begin
                    if (phase_end) begin
                        state <= state_clock_high;
                        mdio_clock <= 1'b1;
                    end
                end
                state_finish: begin
                    if (phase_end) begin
                        state <= state_done;
                    end
                end
                state_done: begin
                    // Hold done until the register block drops start
                    if (!start) begin
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                    mdio_clock <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== design/mdio_shift_datapath.sv ====
`timescale 1ns/1ps

/*
 * MDIO shift datapath
 * Drives preamble and command bits onto the data line, handles the read
 * turnaround and collects the bits returned by the PHY
 */
module mdio_shift_datapath (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 drive_bit,
    input  logic                 sample_bit,
    input  logic                 mdio_data_in,
    input  mdio_pkg::bit_index_t bit_index,
    input  logic [31:0]          command,
    output logic                 mdio_data_out,
    output logic                 mdio_data_enable,
    output logic [31:0]          read_data
);
    import mdio_pkg::*;

    logic [31:0]  frame_word;
    mdio_opcode_t opcode;
    logic [4:0]   word_position;

    // Frame positions 32..63 map to word bits 31..0
    assign word_position = 5'd31 - bit_index[4:0];

    always_ff @(posedge clock) begin
        if (load) begin
            frame_word <= command;
            opcode <= mdio_opcode_t'(command[29:28]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || load) begin
            mdio_data_out <= 1'b1;
            mdio_data_enable <= 1'b0;
        end else if (drive_bit) begin
            if (bit_index < preamble_bits) begin
                mdio_data_out <= 1'b1;
                mdio_data_enable <= 1'b1;
            end else begin
                mdio_data_out <= frame_word[word_position];
                // PHY owns the line from the turnaround on
                mdio_data_enable <= !(opcode == opcode_read && bit_index >= turnaround_bit);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            read_data <= '0;
        end else if (sample_bit && bit_index >= preamble_bits) begin
            read_data[word_position] <= mdio_data_in;
        end
    end

endmodule

// ==== design/mdio_registers.sv ====
`timescale 1ns/1ps

/*
 * MDIO register block
 * Write and read strobes, interrupt enable and status, PHY reset control
 * and the start/done handshake with the frame FSM
 */
module mdio_registers (
    input  logic        clock,
    input  logic        reset,
    input  logic        reg_write,
    input  logic        reg_read,
    input  logic        done,
    input  logic        phy_interrupt_sync,
    input  logic [11:0] reg_address,
    input  logic [31:0] reg_write_data,
    input  logic [31:0] read_data,
    output logic [31:0] reg_read_data,
    output logic [31:0] command,
    output logic        reg_read_valid,
    output logic        start,
    output logic        phy_reset_n,
    output logic        interrupt
);
    import mdio_pkg::*;

    logic [31:0] int_enable;
    logic [31:0] int_status;
    logic [31:0] read_mux;
    logic        phy_reset_release;

    always_comb begin
        int_status = '0;
        // Master is idle once the handshake has fully completed
        int_status[int_mdio_done_bit] = !(start || done);
        int_status[int_phy_bit] = phy_interrupt_sync;
    end

    assign interrupt = |(int_enable & int_status);
    assign phy_reset_n = phy_reset_release;

    always_comb begin
        read_mux = '0;
        case (reg_address)
            reg_int_enable: read_mux = int_enable;
            reg_int_status: read_mux = int_status;
            reg_control: read_mux[control_phy_reset_bit] = phy_reset_release;
            reg_mdio_command: read_mux = command;
            reg_mdio_read: read_mux = read_data;
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reg_read) begin
            reg_read_data <= read_mux;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            int_enable <= '0;
            phy_reset_release <= 1'b0;
            command <= '0;
            start <= 1'b0;
            reg_read_valid <= 1'b0;
        end else begin
            reg_read_valid <= reg_read;
            if (start && done) begin
                start <= 1'b0;
            end
            // A command write wins over the handshake clear
            if (reg_write) begin
                case (reg_address)
                    reg_int_enable: int_enable <= reg_write_data;
                    reg_control: phy_reset_release <= reg_write_data[control_phy_reset_bit];
                    reg_mdio_command: begin
                        command <= reg_write_data;
                        start <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/mdio_master.sv ====
`timescale 1ns/1ps

/*
 * MDIO management master
 * Register-mapped PHY management interface with interrupt support
 */
module mdio_master (
    input  logic        clock,
    input  logic        reset,
    input  logic        reg_write,
    input  logic [11:0] reg_address,
    input  logic [31:0] reg_write_data,
    input  logic        reg_read,
    output logic [31:0] reg_read_data,
    output logic        reg_read_valid,
    output logic        mdio_clock,
    output logic        mdio_data_out,
    output logic        mdio_data_enable,
    input  logic        mdio_data_in,
    input  logic        phy_interrupt,
    output logic        phy_reset_n,
    output logic        interrupt
);
    import mdio_pkg::*;

    logic        start;
    logic        done;
    logic        run;
    logic        phase_end;
    logic        load;
    logic        drive_bit;
    logic        sample_bit;
    bit_index_t  bit_index;
    logic [31:0] command;
    logic [31:0] read_data;
    logic [2:0]  phy_interrupt_stages;
    logic        phy_interrupt_sync;

    // PHY interrupt pin is asynchronous
    always_ff @(posedge clock) begin
        if (reset) begin
            phy_interrupt_stages <= '0;
        end else begin
            phy_interrupt_stages <= {phy_interrupt_stages[1:0], phy_interrupt};
        end
    end

    assign phy_interrupt_sync = phy_interrupt_stages[2];

    mdio_phase_timer mdio_phase_timer_inst (
        .clock     (clock),
        .reset     (reset),
        .run       (run),
        .phase_end (phase_end)
    );

    mdio_frame_fsm mdio_frame_fsm_inst (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .phase_end  (phase_end),
        .run        (run),
        .load       (load),
        .drive_bit  (drive_bit),
        .sample_bit (sample_bit),
        .done       (done),
        .mdio_clock (mdio_clock),
        .bit_index  (bit_index)
    );

    mdio_shift_datapath mdio_shift_datapath_inst (
        .clock            (clock),
        .reset            (reset),
        .load             (load),
        .drive_bit        (drive_bit),
        .sample_bit       (sample_bit),
        .mdio_data_in     (mdio_data_in),
        .bit_index        (bit_index),
        .command          (command),
        .mdio_data_out    (mdio_data_out),
        .mdio_data_enable (mdio_data_enable),
        .read_data        (read_data)
    );

    mdio_registers mdio_registers_inst (
        .clock              (clock),
        .reset              (reset),
        .reg_write          (reg_write),
        .reg_read           (reg_read),
        .done               (done),
        .phy_interrupt_sync (phy_interrupt_sync),
        .reg_address        (reg_address),
        .reg_write_data     (reg_write_data),
        .read_data          (read_data),
        .reg_read_data      (reg_read_data),
        .command            (command),
        .reg_read_valid     (reg_read_valid),
        .start              (start),
        .phy_reset_n        (phy_reset_n),
        .interrupt          (interrupt)
    );

endmodule

// ==== verification/mdio_master_tb.sv ====
`timescale 1ns/1ps

/*
 * MDIO master testbench
 * PHY model, frame and register checks, interrupt and clock timing checks
 */
module mdio_master_tb;
    import mdio_pkg::*;

    logic        clock;
    logic        reset;
    logic        reg_write;
    logic [11:0] reg_address;
    logic [31:0] reg_write_data;
    logic        reg_read;
    logic [31:0] reg_read_data;
    logic        reg_read_valid;
    logic        mdio_clock;
    logic        mdio_data_out;
    logic        mdio_data_enable;
    logic        mdio_data_in;
    logic        phy_interrupt;
    logic        phy_reset_n;
    logic        interrupt;

    integer      seed = 32'hc5d9;
    int          error_count = 0;
    int          check_count = 0;
    int          test_errors = 0;
    logic [31:0] read_value;
    int          read_latency;
    logic [31:0] command_word;
    logic [63:0] frame_word;
    logic        interrupt_seen;

    // PHY model state
    logic        last_clock = 1'b0;
    int          level_cycles = 0;
    int          phase_min = 1000;
    int          phase_max = 0;
    int          rise_count = 0;
    int          fall_count = 0;
    int          first_released;
    logic [63:0] captured_bits;
    int          captured_count;
    logic        read_active = 1'b0;
    logic [15:0] phy_word;

    mdio_master mdio_master_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [63:0] expected_frame(input logic [31:0] command);
        return {{preamble_bits{1'b1}}, command};
    endfunction

    // Register contents the PHY returns for a given address pair
    function automatic logic [15:0] phy_value(input logic [4:0] phy_address,
                                              input logic [4:0] register_address);
        return {register_address, 6'h2d, phy_address} ^ 16'h9c31;
    endfunction

    function automatic logic [31:0] expected_status(input logic idle, input logic phy_irq);
        logic [31:0] status;
        status = '0;
        status[int_mdio_done_bit] = idle;
        status[int_phy_bit] = phy_irq;
        return status;
    endfunction

    // Clause 22 frame with start 01, opcode, PHY and register address, turnaround 10 and data
    function automatic logic [31:0] make_command(input logic [1:0] opcode,
                                                 input logic [31:0] random_bits);
        return {2'b01, opcode, random_bits[27:18], 2'b10, random_bits[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("** Error: %s expected %h got %h", name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout: %s", reason);
        $display("Test failed");
        $finish;
    endtask

    task automatic finish_test(input int number, input string name);
        $display("Test %0d %s: %s", number, name, (test_errors == 0) ? "ok" : "mismatch");
        test_errors = 0;
    endtask

    // Drive the PHY side of the line after each falling management clock
    task automatic drive_phy_bit(input int position);
        if (position == turnaround_bit) begin
            read_active = (captured_bits[11:10] == opcode_read);
            phy_word = phy_value(captured_bits[9:5], captured_bits[4:0]);
            mdio_data_in <= 1'b1;
        end else if (read_active && position == turnaround_bit + 1) begin
            mdio_data_in <= 1'b0;
        end else if (read_active && position > turnaround_bit + 1 && position < frame_bits) begin
            mdio_data_in <= phy_word[frame_bits - 1 - position];
        end else begin
            mdio_data_in <= 1'b1;
        end
    endtask

    always @(posedge clock) begin
        if (mdio_clock != last_clock) begin
            // Idle low time before the start rise is not a frame phase
            if (!(mdio_clock && rise_count == 0)) begin
                if (level_cycles < phase_min) phase_min = level_cycles;
                if (level_cycles > phase_max) phase_max = level_cycles;
            end
            level_cycles = 1;
            if (mdio_clock) begin
                // Rise k+1 samples frame bit k
                if (rise_count > 0) begin
                    if (mdio_data_enable) begin
                        captured_bits = {captured_bits[62:0], mdio_data_out};
                        captured_count++;
                    end else if (first_released == frame_bits) begin
                        first_released = rise_count - 1;
                    end
                end
                rise_count++;
            end else begin
                drive_phy_bit(fall_count);
                fall_count++;
            end
        end else begin
            level_cycles++;
        end
        last_clock = mdio_clock;
    end

    always @(posedge clock) begin
        if (interrupt) interrupt_seen = 1'b1;
    end

    task automatic write_register(input logic [11:0] address, input logic [31:0] data);
        @(posedge clock);
        reg_write <= 1'b1;
        reg_address <= address;
        reg_write_data <= data;
        @(posedge clock);
        reg_write <= 1'b0;
    endtask

    task automatic read_register(input logic [11:0] address);
        int cycles;
        @(posedge clock);
        reg_read <= 1'b1;
        reg_address <= address;
        @(posedge clock);
        reg_read <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 16) abort_run("no reg_read_valid after a read strobe");
        end while (!reg_read_valid);
        read_latency = cycles;
        read_value = reg_read_data;
    endtask

    task automatic wait_frame_done();
        int polls;
        polls = 0;
        read_register(reg_int_status);
        while (!read_value[int_mdio_done_bit]) begin
            polls++;
            if (polls > 4000) abort_run("MDIO frame never reported done");
            read_register(reg_int_status);
        end
    endtask

    task automatic wait_interrupt(input string reason);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 5000) abort_run(reason);
        end while (!interrupt);
    endtask

    // Clear the model between posedges so it sees a clean frame
    task automatic prepare_frame();
        @(negedge clock);
        rise_count = 0;
        fall_count = 0;
        first_released = frame_bits;
        captured_count = 0;
        captured_bits = '0;
        read_active = 1'b0;
        interrupt_seen = 1'b0;
    endtask

    task automatic run_frame(input logic [31:0] command);
        prepare_frame();
        write_register(reg_mdio_command, command);
        wait_frame_done();
    endtask

    initial begin
        reset = 1'b1;
        reg_write = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        reg_read = 1'b0;
        mdio_data_in = 1'b1;
        phy_interrupt = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        check_value("mdio_clock", mdio_clock, 1'b0);
        check_value("mdio_data_enable", mdio_data_enable, 1'b0);
        check_value("mdio_data_out", mdio_data_out, 1'b1);
        check_value("reg_read_valid", reg_read_valid, 1'b0);
        check_value("interrupt", interrupt, 1'b0);
        check_value("phy_reset_n", phy_reset_n, 1'b0);
        read_register(reg_int_enable);
        check_value("reg_int_enable", read_value, 32'h0);
        check_value("reg_read_valid latency", read_latency, 1);
        read_register(reg_int_status);
        check_value("reg_int_status", read_value, expected_status(1'b1, 1'b0));
        check_value("reg_read_valid latency", read_latency, 1);
        read_register(reg_control);
        check_value("reg_control", read_value, 32'h0);
        check_value("reg_read_valid latency", read_latency, 1);
        read_register(reg_mdio_command);
        check_value("reg_mdio_command", read_value, 32'h0);
        check_value("reg_read_valid latency", read_latency, 1);
        read_register(reg_mdio_read);
        check_value("reg_mdio_read", read_value, 32'h0);
        check_value("reg_read_valid latency", read_latency, 1);
        finish_test(1, "reset state");

        command_word = make_command(opcode_write, $random(seed));
        run_frame(command_word);
        check_value("captured bit count", captured_count, frame_bits);
        check_value("mdio_data_out frame", captured_bits, expected_frame(command_word));
        check_value("first released bit", first_released, frame_bits);
        read_register(reg_mdio_command);
        check_value("reg_mdio_command", read_value, command_word);
        finish_test(2, "write frame");

        command_word = make_command(opcode_read, $random(seed));
        frame_word = expected_frame(command_word);
        run_frame(command_word);
        check_value("first released bit", first_released, turnaround_bit);
        check_value("captured bit count", captured_count, turnaround_bit);
        check_value("mdio_data_out frame head", captured_bits[turnaround_bit-1:0],
                    frame_word[frame_bits-1 -: turnaround_bit]);
        read_register(reg_mdio_read);
        check_value("reg_mdio_read[15:0]", read_value[15:0],
                    phy_value(command_word[27:23], command_word[22:18]));
        finish_test(3, "read frame");

        write_register(reg_int_enable, 32'h1 << int_mdio_done_bit);
        prepare_frame();
        write_register(reg_mdio_command, make_command(opcode_write, $random(seed)));
        @(posedge clock);
        check_value("interrupt during frame", interrupt, 1'b0);
        wait_interrupt("interrupt did not rise after the frame");
        write_register(reg_int_enable, 32'h0);
        run_frame(make_command(opcode_write, $random(seed)));
        check_value("interrupt while disabled", interrupt_seen, 1'b0);
        write_register(reg_int_enable, 32'h1 << int_phy_bit);
        @(posedge clock);
        check_value("interrupt before phy_interrupt", interrupt, 1'b0);
        phy_interrupt <= 1'b1;
        wait_interrupt("interrupt did not follow phy_interrupt");
        read_register(reg_int_status);
        check_value("reg_int_status", read_value, expected_status(1'b1, 1'b1));
        phy_interrupt <= 1'b0;
        finish_test(4, "interrupts");

        check_value("mdio_clock shortest phase", phase_min, phase_cycles);
        check_value("mdio_clock longest phase", phase_max, phase_cycles);
        write_register(reg_control, 32'h1 << control_phy_reset_bit);
        @(posedge clock);
        check_value("phy_reset_n", phy_reset_n, 1'b1);
        read_register(reg_control);
        check_value("reg_control", read_value, 32'h1 << control_phy_reset_bit);
        finish_test(5, "clock timing and PHY reset");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/mdio_pkg.sv
design/mdio_phase_timer.sv
design/mdio_frame_fsm.sv
design/mdio_shift_datapath.sv
design/mdio_registers.sv
design/mdio_master.sv
verification/mdio_master_tb.sv

// ==== Bender.yml ====
package:
  name: mdio_master

sources:
  - files:
      - design/mdio_pkg.sv
      - design/mdio_phase_timer.sv
      - design/mdio_frame_fsm.sv
      - design/mdio_shift_datapath.sv
      - design/mdio_registers.sv
      - design/mdio_master.sv
  - target: simulation
    files:
      - verification/mdio_master_tb.sv
